/* Makefile */
# Verilator build and run of the chip I/O testbench

VERILATOR ?= verilator
TOP       ?= tb_chip_io_top
FILELIST  ?= compile.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	mkdir -p $(BUILD_DIR)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR)/obj -o $(TOP)
	$(BUILD_DIR)/obj/$(TOP) | tee $(LOG)
	@if grep -qF -- '$(PASS_MSG)' $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

/* bench/tb_chip_io_top.sv */
/* Testbench for chip_io_top on the default pad indices. Pads loop back where
   oe is high and take stimulus values elsewhere. TCK is held 6 clocks per phase. */

module tb_chip_io_top;

  import chip_io_pkg::*;

  localparam int unsigned JtagEnIdx = 7;
  localparam int unsigned TrstIdx   = 6;
  localparam int unsigned TckIdx    = 8;
  localparam int unsigned TmsIdx    = 9;
  localparam int unsigned TdiIdx    = 10;
  localparam int unsigned TdoIdx    = 11;
  localparam io_vec_t     TieOff    = io_vec_t'(1) << TmsIdx;
  localparam io_vec_t     StrapBit  = io_vec_t'(1) << JtagEnIdx;
  // Keep the strap low in the register tests
  localparam reg_data_t   OeSafe    = ~reg_data_t'(StrapBit);
  localparam reg_data_t   MioSafe   = ~(reg_data_t'(1) << (AttrDw * JtagEnIdx));

  localparam int TckHalf       = 6;
  // Summed over all six tests, then doubled
  localparam int JtagTicks     = 112;
  localparam int RegAccesses   = 125;
  localparam int IdleCycles    = 60;
  localparam int TimeoutCycles = 2 * (JtagTicks * 2 * TckHalf + RegAccesses * 2 + IdleCycles);

  logic        clk, rst_n;
  logic        host_req, host_ack;
  reg_req_t    req;
  reg_rsp_t    rsp;
  io_vec_t     pad_in, pad_out, pad_oe, ext_in;
  logic [31:0] lcg_state;
  int          errors      = 0;
  int          checks      = 0;
  int          rise_errors = 0;
  int          fall_errors = 0;
  int          test_start  = 0;
  int          cycles      = 0;

  chip_io_top #(
    .JtagEnIdx    ( JtagEnIdx ),
    .TrstIdx      ( TrstIdx   ),
    .TckIdx       ( TckIdx    ),
    .TmsIdx       ( TmsIdx    ),
    .TdiIdx       ( TdiIdx    ),
    .TdoIdx       ( TdoIdx    ),
    .TieOffValues ( TieOff    )
  ) chip_io_top_i (
    .clk_i     ( clk     ),
    .rst_n_i   ( rst_n   ),
    .reg_req_i ( req     ),
    .reg_rsp_o ( rsp     ),
    .pad_in_i  ( pad_in  ),
    .pad_out_o ( pad_out ),
    .pad_oe_o  ( pad_oe  )
  );

  // Driven pads read back their own value
  assign pad_in   = (pad_oe & pad_out) | (~pad_oe & ext_in);
  assign host_req = req.req;
  assign host_ack = rsp.ack;

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  initial begin
    while (cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d clock cycles", TimeoutCycles);
    $display("*** FAILED ***");
    $finish;
  end

  assert property (@(posedge clk) disable iff (!rst_n) $rose(host_req) |=> $rose(host_ack))
    else begin
      rise_errors++;
      $display("Handshake error: ack did not rise one cycle after req at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (!rst_n) $fell(host_req) |=> $fell(host_ack))
    else begin
      fall_errors++;
      $display("Handshake error: ack did not fall one cycle after req at %0t", $time);
    end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];              // Upper bits are the better ones
  endfunction

  function automatic int total_errors();
    return errors + rise_errors + fall_errors;
  endfunction

  // One bit of every pad attribute, MIO from the low register
  function automatic io_vec_t attr_field(input reg_data_t mio, input reg_data_t dio,
                                         input int bit_idx);
    io_vec_t v;
    for (int i = 0; i < NMioPads; i++) begin
      v[i] = mio[AttrDw * i + bit_idx];
    end
    for (int i = 0; i < NDioPads; i++) begin
      v[NMioPads + i] = dio[AttrDw * i + bit_idx];
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_latency(input string edge_name, input int n);
    checks++;
    assert (n == 1) else begin
      errors++;
      $display("Handshake error: ack %s %0d cycles after req changed", edge_name, n);
    end
  endtask

  // Called at 2 time units after a rising edge, returns at the same point
  task automatic reg_access(input logic we, input reg_addr_t addr, input reg_data_t wdata,
                            output reg_data_t rdata);
    int n;
    req.req   = 1'b1;
    req.we    = we;
    req.addr  = addr;
    req.wdata = wdata;
    n = 0;
    do begin
      @(posedge clk);
      #2;
      n++;
    end while (!rsp.ack);
    check_latency("rose", n);
    rdata   = rsp.rdata;
    req.req = 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      #2;
      n++;
    end while (rsp.ack);
    check_latency("fell", n);
  endtask

  task automatic reg_write(input reg_addr_t addr, input reg_data_t wdata);
    reg_data_t unused;
    reg_access(1'b1, addr, wdata, unused);
  endtask

  task automatic reg_read(input reg_addr_t addr, output reg_data_t rdata);
    reg_access(1'b0, addr, '0, rdata);
  endtask

  task automatic settle();
    repeat (3) @(posedge clk);            // Two synchronizer flops plus the read edge
    #2;
  endtask

  // TDO is sampled at the end of the low phase, before TCK rises
  task automatic jtag_tick(input logic tms, input logic tdi, output logic tdo);
    ext_in[TckIdx] = 1'b0;
    ext_in[TmsIdx] = tms;
    ext_in[TdiIdx] = tdi;
    repeat (TckHalf) @(posedge clk);
    #2;
    tdo = pad_out[TdoIdx];
    ext_in[TckIdx] = 1'b1;
    repeat (TckHalf) @(posedge clk);
    #2;
  endtask

  task automatic jtag_reset_tms();
    logic tdo;
    repeat (5) jtag_tick(1'b1, 1'b0, tdo);
    jtag_tick(1'b0, 1'b0, tdo);           // Run-Test/Idle
  endtask

  // Full DR or IR scan from Run-Test/Idle back to Run-Test/Idle, LSB first
  task automatic jtag_shift(input logic is_ir, input logic [31:0] din, input int nbits,
                            output logic [31:0] dout);
    logic tdo;
    dout = '0;
    jtag_tick(1'b1, 1'b0, tdo);
    if (is_ir) begin
      jtag_tick(1'b1, 1'b0, tdo);
    end
    jtag_tick(1'b0, 1'b0, tdo);           // Capture
    jtag_tick(1'b0, 1'b0, tdo);           // Into Shift
    for (int i = 0; i < nbits; i++) begin
      jtag_tick(i == nbits - 1, din[i], tdo);
      dout[i] = tdo;
      if (i < nbits - 1) begin
        check_value("pad_oe_o[TdoIdx]", 32'(pad_oe[TdoIdx]), 32'd1);
      end
    end
    jtag_tick(1'b1, 1'b0, tdo);           // Update
    jtag_tick(1'b0, 1'b0, tdo);
  endtask

  task automatic report_test(input string name);
    int n;
    n = total_errors() - test_start;
    $display("Test %-14s %s (%0d errors)", name, (n == 0) ? "ok" : "failed", n);
    test_start = total_errors();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reg_data_t   rd, out_v, oe_v, mio_v, dio_v, pattern;
    io_vec_t     inv, od, exp_out, exp_oe, exp_in;
    logic [31:0] dout;
    logic        tdo;
    rst_n     = 1'b0;
    req       = '0;
    ext_in    = '0;
    lcg_state = 32'h0bda_2672;
    repeat (4) @(posedge clk);
    #2 rst_n = 1'b1;
    settle();

    // 1. Reset values and handshake timing
    check_value("reg_rsp_o.ack", 32'(rsp.ack), 32'd0);
    check_value("pad_oe_o", 32'(pad_oe), 32'd0);
    reg_write(RegIoOut, 16'h0a5c);
    reg_read(RegIoOut, rd);
    check_value("IO_OUT", 32'(rd), 32'h0a5c);
    report_test("handshake");

    // 2. Register round trip, fields masked to their widths
    for (int k = 0; k < 8; k++) begin
      out_v = rand16();
      oe_v  = rand16() & OeSafe;
      mio_v = rand16() & MioSafe;
      dio_v = rand16();
      reg_write(RegIoOut, out_v);
      reg_write(RegIoOe, oe_v);
      reg_write(RegMioAttr, mio_v);
      reg_write(RegDioAttr, dio_v);
      reg_read(RegIoOut, rd);
      check_value("IO_OUT", 32'(rd), 32'(out_v & 16'h0fff));
      reg_read(RegIoOe, rd);
      check_value("IO_OE", 32'(rd), 32'(oe_v & 16'h0fff));
      reg_read(RegMioAttr, rd);
      check_value("MIO_ATTR", 32'(rd), 32'(mio_v));
      reg_read(RegDioAttr, rd);
      check_value("DIO_ATTR", 32'(rd), 32'(dio_v & 16'h00ff));
    end
    for (int a = 5; a < 8; a++) begin
      reg_write(reg_addr_t'(a), rand16());
      reg_read(reg_addr_t'(a), rd);
      check_value("unmapped rdata", 32'(rd), 32'd0);
    end
    report_test("round trip");

    // 3. Output mapping with invert and open-drain, read back through the loop
    for (int k = 0; k < 8; k++) begin
      ext_in = io_vec_t'(rand16()) & ~StrapBit;
      out_v  = rand16();
      oe_v   = rand16() & OeSafe;
      mio_v  = rand16() & MioSafe;
      dio_v  = rand16();
      reg_write(RegIoOut, out_v);
      reg_write(RegIoOe, oe_v);
      reg_write(RegMioAttr, mio_v);
      reg_write(RegDioAttr, dio_v);
      inv     = attr_field(mio_v, dio_v, 0);
      od      = attr_field(mio_v, dio_v, 1);
      exp_out = io_vec_t'(out_v) ^ inv;
      exp_oe  = io_vec_t'(oe_v) & ~(od & exp_out);
      check_value("pad_out_o", 32'(pad_out), 32'(exp_out));
      check_value("pad_oe_o", 32'(pad_oe), 32'(exp_oe));
      settle();
      reg_read(RegIoIn, rd);
      exp_in = (exp_oe & io_vec_t'(out_v)) | (~exp_oe & (ext_in ^ inv));
      check_value("IO_IN", 32'(rd), 32'(exp_in));
    end
    report_test("pad mapping");

    // 4. Input path with nothing driven
    reg_write(RegIoOe, 16'h0000);
    mio_v = rand16() & MioSafe;
    dio_v = rand16();
    reg_write(RegMioAttr, mio_v);
    reg_write(RegDioAttr, dio_v);
    inv = attr_field(mio_v, dio_v, 0);
    for (int k = 0; k < 6; k++) begin
      ext_in = io_vec_t'(rand16()) & ~StrapBit;
      settle();
      reg_read(RegIoIn, rd);
      check_value("IO_IN", 32'(rd), 32'(ext_in ^ inv));
    end
    report_test("input path");

    // 5. Strap high, tie-offs seen by the core, IDCODE on TDO
    reg_write(RegMioAttr, 16'h0000);
    reg_write(RegDioAttr, 16'h0000);
    ext_in = (io_vec_t'(rand16()) & io_vec_t'(12'h03f)) | StrapBit |
             (io_vec_t'(1) << TrstIdx) | (io_vec_t'(1) << TckIdx) |
             (io_vec_t'(1) << TdiIdx) | (io_vec_t'(1) << TdoIdx);
    settle();
    reg_read(RegIoIn, rd);
    // Overlaid pads read their tie-off values and not the driven level
    exp_in          = ext_in;
    exp_in[TckIdx]  = TieOff[TckIdx];
    exp_in[TmsIdx]  = TieOff[TmsIdx];
    exp_in[TdiIdx]  = TieOff[TdiIdx];
    exp_in[TrstIdx] = TieOff[TrstIdx];
    exp_in[TdoIdx]  = TieOff[TdoIdx];
    check_value("IO_IN", 32'(rd), 32'(exp_in));
    jtag_reset_tms();
    jtag_shift(1'b0, 32'h0, 32, dout);
    check_value("TDO IDCODE", dout, IdcodeValue);
    report_test("jtag idcode");

    // 6. BYPASS delays by one bit, TRST brings IDCODE back
    jtag_shift(1'b1, 32'hf, 4, dout);
    check_value("TDO IR capture[1:0]", 32'(dout[1:0]), 32'h1);
    pattern = rand16();
    jtag_shift(1'b0, 32'(pattern), 16, dout);
    check_value("TDO BYPASS", 32'(dout[15:0]), 32'({pattern[14:0], 1'b0}));
    ext_in[TrstIdx] = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    ext_in[TrstIdx] = 1'b1;
    settle();
    jtag_tick(1'b0, 1'b0, tdo);
    jtag_shift(1'b0, 32'h0, 32, dout);
    check_value("TDO IDCODE", dout, IdcodeValue);
    report_test("bypass trst");

    $display("Summary: %0d checks, %0d errors", checks, total_errors());
    if (total_errors() == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* compile.f */
logic/chip_io_pkg.sv
logic/pad_ring.sv
logic/jtag_mux.sv
logic/jtag_tap.sv
logic/io_reg_core.sv
logic/chip_io_top.sv
bench/tb_chip_io_top.sv

/* logic/chip_io_pkg.sv */
/* Shared pad counts, register map and bus types of the chip I/O subsystem.
   MIO pads sit at indices 0 to 7 of every pad vector and DIO pads at 8 to 11. */

package chip_io_pkg;

  parameter int NMioPads = 8;
  parameter int NDioPads = 4;
  parameter int NumIOs   = NMioPads + NDioPads;
  parameter int AttrDw   = 2;   // Bit 0 invert, bit 1 open-drain
  parameter int RegAw    = 3;
  parameter int RegDw    = 16;

  // IEEE 1149.1 requires bit 0 set
  parameter logic [31:0] IdcodeValue = 32'h0c10_64a3;

  typedef logic [NumIOs-1:0] io_vec_t;
  typedef logic [AttrDw-1:0] pad_attr_t;
  typedef logic [RegAw-1:0]  reg_addr_t;
  typedef logic [RegDw-1:0]  reg_data_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  parameter reg_addr_t RegIoOut   = 3'd0;
  parameter reg_addr_t RegIoOe    = 3'd1;
  parameter reg_addr_t RegIoIn    = 3'd2;  // Read only
  parameter reg_addr_t RegMioAttr = 3'd3;
  parameter reg_addr_t RegDioAttr = 3'd4;

  // Host side of the four-phase port
  typedef struct packed {
    logic      req;
    logic      we;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  typedef struct packed {
    logic      ack;
    reg_data_t rdata;
  } reg_rsp_t;

  typedef enum logic [3:0] {
    TestLogicReset, RunTestIdle,
    SelectDrScan, CaptureDr, ShiftDr, Exit1Dr, PauseDr, Exit2Dr, UpdateDr,
    SelectIrScan, CaptureIr, ShiftIr, Exit1Ir, PauseIr, Exit2Ir, UpdateIr
  } tap_state_t;

endpackage

/* logic/chip_io_top.sv */
/* Chip I/O top. Pads appear as separate in, out and oe vectors. The strap
   at JtagEnIdx hands five pads to the TAP. */

module chip_io_top #(
  parameter int unsigned          JtagEnIdx    = 7,
  parameter int unsigned          TrstIdx      = 6,
  parameter int unsigned          TckIdx       = 8,
  parameter int unsigned          TmsIdx       = 9,
  parameter int unsigned          TdiIdx       = 10,
  parameter int unsigned          TdoIdx       = 11,
  parameter chip_io_pkg::io_vec_t TieOffValues = chip_io_pkg::io_vec_t'(1) << TmsIdx
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Host register port
  input  chip_io_pkg::reg_req_t reg_req_i,
  output chip_io_pkg::reg_rsp_t reg_rsp_o,
  // Pads
  input  chip_io_pkg::io_vec_t  pad_in_i,
  output chip_io_pkg::io_vec_t  pad_out_o,
  output chip_io_pkg::io_vec_t  pad_oe_o
);

  import chip_io_pkg::*;

  logic                   rst_n;                 // Synchronized release
  io_vec_t                in_padring, out_padring, oe_padring;
  io_vec_t                in_core, out_core, oe_core;
  pad_attr_t [NumIOs-1:0] attr;
  logic                   jtag_tck, jtag_tms, jtag_tdi, jtag_trst_n;
  logic                   jtag_tdo, jtag_tdo_en;

  ////////////////////////////////////////////////////////////////////////////
  // Pad ring and JTAG overlay
  ////////////////////////////////////////////////////////////////////////////

  pad_ring pad_ring_i (
    .clk_i     ( clk_i       ),
    .rst_n_i   ( rst_n_i     ),
    .rst_n_o   ( rst_n       ),
    .pad_in_i  ( pad_in_i    ),
    .pad_out_o ( pad_out_o   ),
    .pad_oe_o  ( pad_oe_o    ),
    .in_o      ( in_padring  ),
    .out_i     ( out_padring ),
    .oe_i      ( oe_padring  ),
    .attr_i    ( attr        )
  );

  jtag_mux #(
    .JtagEnIdx    ( JtagEnIdx    ),
    .TrstIdx      ( TrstIdx      ),
    .TckIdx       ( TckIdx       ),
    .TmsIdx       ( TmsIdx       ),
    .TdiIdx       ( TdiIdx       ),
    .TdoIdx       ( TdoIdx       ),
    .TieOffValues ( TieOffValues )
  ) jtag_mux_i (
    .in_padring_i  ( in_padring  ),
    .out_padring_o ( out_padring ),
    .oe_padring_o  ( oe_padring  ),
    .in_core_o     ( in_core     ),
    .out_core_i    ( out_core    ),
    .oe_core_i     ( oe_core     ),
    .jtag_tck_o    ( jtag_tck    ),
    .jtag_tms_o    ( jtag_tms    ),
    .jtag_tdi_o    ( jtag_tdi    ),
    .jtag_trst_no  ( jtag_trst_n ),
    .jtag_tdo_i    ( jtag_tdo    ),
    .jtag_tdo_en_i ( jtag_tdo_en )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Core side
  ////////////////////////////////////////////////////////////////////////////

  jtag_tap jtag_tap_i (
    .clk_i    ( clk_i       ),
    .rst_n_i  ( rst_n       ),
    .tck_i    ( jtag_tck    ),
    .tms_i    ( jtag_tms    ),
    .tdi_i    ( jtag_tdi    ),
    .trst_ni  ( jtag_trst_n ),
    .tdo_o    ( jtag_tdo    ),
    .tdo_en_o ( jtag_tdo_en )
  );

  io_reg_core io_reg_core_i (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n     ),
    .reg_req_i ( reg_req_i ),
    .reg_rsp_o ( reg_rsp_o ),
    .io_in_i   ( in_core   ),
    .io_out_o  ( out_core  ),
    .io_oe_o   ( oe_core   ),
    .attr_o    ( attr      )
  );

endmodule

/* logic/io_reg_core.sv */
/* Register block behind the four-phase req/ack port. One access per handshake;
   the host must hold req, we, addr and wdata until ack is seen. */

module io_reg_core (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  input  chip_io_pkg::reg_req_t                           reg_req_i,
  output chip_io_pkg::reg_rsp_t                           reg_rsp_o,
  input  chip_io_pkg::io_vec_t                            io_in_i,
  output chip_io_pkg::io_vec_t                            io_out_o,
  output chip_io_pkg::io_vec_t                            io_oe_o,
  output chip_io_pkg::pad_attr_t [chip_io_pkg::NumIOs-1:0] attr_o
);

  import chip_io_pkg::*;

  localparam int MioAttrW = NMioPads * AttrDw;
  localparam int DioAttrW = NDioPads * AttrDw;

  logic                       ack_q;
  logic                       access;
  reg_data_t                  rdata_q, rdata_d;
  io_vec_t                    io_out_q, io_oe_q;
  pad_attr_t [NMioPads-1:0]   mio_attr_q;
  pad_attr_t [NDioPads-1:0]   dio_attr_q;

  // First edge of a new request
  assign access = reg_req_i.req & ~ack_q;

  // Read mux, unmapped addresses give 0
  always_comb begin
    rdata_d = '0;
    case (reg_req_i.addr)
      RegIoOut:   rdata_d = reg_data_t'(io_out_q);
      RegIoOe:    rdata_d = reg_data_t'(io_oe_q);
      RegIoIn:    rdata_d = reg_data_t'(io_in_i);
      RegMioAttr: rdata_d = reg_data_t'(mio_attr_q);
      RegDioAttr: rdata_d = reg_data_t'(dio_attr_q);
      default:    rdata_d = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake and register writes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q      <= 1'b0;
      io_out_q   <= '0;
      io_oe_q    <= '0;
      mio_attr_q <= '0;
      dio_attr_q <= '0;
    end else begin
      if (access) begin
        ack_q <= 1'b1;
        if (reg_req_i.we) begin
          case (reg_req_i.addr)
            RegIoOut:   io_out_q   <= reg_req_i.wdata[NumIOs-1:0];
            RegIoOe:    io_oe_q    <= reg_req_i.wdata[NumIOs-1:0];
            RegMioAttr: mio_attr_q <= reg_req_i.wdata[MioAttrW-1:0];
            RegDioAttr: dio_attr_q <= reg_req_i.wdata[DioAttrW-1:0];
            default:    ;       // RegIoIn and holes ignore writes
          endcase
        end
      end else if (!reg_req_i.req) begin
        ack_q <= 1'b0;
      end
    end
  end

  // Held while ack is high
  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rsp_o.ack   = ack_q;
  assign reg_rsp_o.rdata = rdata_q;

  assign io_out_o = io_out_q;
  assign io_oe_o  = io_oe_q;
  assign attr_o   = {dio_attr_q, mio_attr_q};   // DIO attributes on top

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(reg_rsp_o.ack) |-> $past(reg_req_i.req))
    else $error("ack rose without req");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(reg_rsp_o.ack) |-> !$past(reg_req_i.req))
    else $error("ack fell while req still high");

endmodule

/* logic/jtag_mux.sv */
/* JTAG overlay on the pad vectors, selected by an active high strap pin.
   The strap is taken from the synchronized inputs, so it switches two clocks late. */

module jtag_mux #(
  parameter int unsigned          JtagEnIdx    = 7,
  parameter int unsigned          TrstIdx      = 6,
  parameter int unsigned          TckIdx       = 8,
  parameter int unsigned          TmsIdx       = 9,
  parameter int unsigned          TdiIdx       = 10,
  parameter int unsigned          TdoIdx       = 11,
  parameter chip_io_pkg::io_vec_t TieOffValues = chip_io_pkg::io_vec_t'(1) << TmsIdx
) (
  // Pad ring side
  input  chip_io_pkg::io_vec_t in_padring_i,
  output chip_io_pkg::io_vec_t out_padring_o,
  output chip_io_pkg::io_vec_t oe_padring_o,
  // Core side
  output chip_io_pkg::io_vec_t in_core_o,
  input  chip_io_pkg::io_vec_t out_core_i,
  input  chip_io_pkg::io_vec_t oe_core_i,
  // TAP side
  output logic                 jtag_tck_o,
  output logic                 jtag_tms_o,
  output logic                 jtag_tdi_o,
  output logic                 jtag_trst_no,
  input  logic                 jtag_tdo_i,
  input  logic                 jtag_tdo_en_i
);

  import chip_io_pkg::*;

  // The five pads taken over by the TAP
  localparam io_vec_t JtagMask = (io_vec_t'(1) << TckIdx) | (io_vec_t'(1) << TmsIdx) |
                                 (io_vec_t'(1) << TdiIdx) | (io_vec_t'(1) << TrstIdx) |
                                 (io_vec_t'(1) << TdoIdx);
  localparam io_vec_t StrapMask = io_vec_t'(1) << JtagEnIdx;

  // An index out of range shifts to zero, so one count covers both rules
  if ($countones(JtagMask | StrapMask) != 6) begin : gen_idx_check
    $fatal(1, "jtag_mux: pad indices must be distinct and below NumIOs");
  end

  logic jtag_en;

  assign jtag_en = in_padring_i[JtagEnIdx];

  always_comb begin
    // Straight pass-through by default
    in_core_o     = in_padring_i;
    out_padring_o = out_core_i;
    oe_padring_o  = oe_core_i;
    jtag_tck_o    = 1'b0;
    jtag_tms_o    = 1'b1;       // Idle TMS keeps the TAP parked
    jtag_tdi_o    = 1'b0;
    jtag_trst_no  = 1'b0;       // TAP held in reset
    if (jtag_en) begin
      jtag_tck_o   = in_padring_i[TckIdx];
      jtag_tms_o   = in_padring_i[TmsIdx];
      jtag_tdi_o   = in_padring_i[TdiIdx];
      jtag_trst_no = in_padring_i[TrstIdx];
      // Core sees fixed values on the overlaid pads
      in_core_o    = (in_padring_i & ~JtagMask) | (TieOffValues & JtagMask);
      oe_padring_o = oe_core_i & ~JtagMask;
      out_padring_o[TdoIdx] = jtag_tdo_i;
      oe_padring_o[TdoIdx]  = jtag_tdo_en_i;
    end
  end

endmodule

/* logic/jtag_tap.sv */
/* IEEE 1149.1 TAP with IDCODE and BYPASS, run from the system clock.
   TCK must be stable for at least 4 clocks per phase. TRST is sampled, not async. */

module jtag_tap (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic tck_i,
  input  logic tms_i,
  input  logic tdi_i,
  input  logic trst_ni,
  output logic tdo_o,
  output logic tdo_en_o
);

  import chip_io_pkg::*;

  localparam logic [3:0] IrIdcode  = 4'b0001;  // All other codes select BYPASS
  localparam logic [3:0] IrCapture = 4'b0101;  // Low bits 01 as the standard asks

  logic        tck_q, tck_rise, tck_fall;
  tap_state_t  state_q, state_d;
  logic [3:0]  ir_q, ir_sr_q;
  logic [31:0] idcode_sr_q;
  logic        bypass_q, tdo_q, idcode_sel;

  assign tck_rise   = tck_i & ~tck_q;
  assign tck_fall   = ~tck_i & tck_q;
  assign idcode_sel = (ir_q == IrIdcode);

  always_comb begin
    case (state_q)
      TestLogicReset: state_d = tms_i ? TestLogicReset : RunTestIdle;
      RunTestIdle:    state_d = tms_i ? SelectDrScan   : RunTestIdle;
      SelectDrScan:   state_d = tms_i ? SelectIrScan   : CaptureDr;
      CaptureDr:      state_d = tms_i ? Exit1Dr        : ShiftDr;
      ShiftDr:        state_d = tms_i ? Exit1Dr        : ShiftDr;
      Exit1Dr:        state_d = tms_i ? UpdateDr       : PauseDr;
      PauseDr:        state_d = tms_i ? Exit2Dr        : PauseDr;
      Exit2Dr:        state_d = tms_i ? UpdateDr       : ShiftDr;
      UpdateDr:       state_d = tms_i ? SelectDrScan   : RunTestIdle;
      SelectIrScan:   state_d = tms_i ? TestLogicReset : CaptureIr;
      CaptureIr:      state_d = tms_i ? Exit1Ir        : ShiftIr;
      ShiftIr:        state_d = tms_i ? Exit1Ir        : ShiftIr;
      Exit1Ir:        state_d = tms_i ? UpdateIr       : PauseIr;
      PauseIr:        state_d = tms_i ? Exit2Ir        : PauseIr;
      Exit2Ir:        state_d = tms_i ? UpdateIr       : ShiftIr;
      UpdateIr:       state_d = tms_i ? SelectDrScan   : RunTestIdle;
      default:        state_d = TestLogicReset;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM and instruction register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tck_q   <= 1'b0;
      state_q <= TestLogicReset;
      ir_q    <= IrIdcode;
    end else begin
      tck_q <= tck_i;
      if (!trst_ni) begin
        state_q <= TestLogicReset;
        ir_q    <= IrIdcode;
      end else begin
        if (tck_rise) begin
          state_q <= state_d;
        end
        if (state_q == TestLogicReset) begin
          ir_q <= IrIdcode;
        end else if (tck_rise && state_q == UpdateIr) begin
          ir_q <= ir_sr_q;          // Latched when leaving Update-IR
        end
      end
    end
  end

  // Shift paths, captured and shifted on TCK rise
  always_ff @(posedge clk_i) begin
    if (tck_rise) begin
      case (state_q)
        CaptureDr: begin
          idcode_sr_q <= IdcodeValue;
          bypass_q    <= 1'b0;
        end
        ShiftDr: begin
          idcode_sr_q <= {tdi_i, idcode_sr_q[31:1]};
          bypass_q    <= tdi_i;
        end
        CaptureIr: ir_sr_q <= IrCapture;
        ShiftIr:   ir_sr_q <= {tdi_i, ir_sr_q[3:1]};
        default:   ;
      endcase
    end
    if (tck_fall) begin
      if (state_q == ShiftIr) begin
        tdo_q <= ir_sr_q[0];
      end else begin
        tdo_q <= idcode_sel ? idcode_sr_q[0] : bypass_q;
      end
    end
  end

  assign tdo_o    = tdo_q;
  assign tdo_en_o = (state_q == ShiftDr) || (state_q == ShiftIr);

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !trst_ni |=> state_q == TestLogicReset)
    else $error("TAP not in Test-Logic-Reset after TRST");

endmodule

/* logic/pad_ring.sv */
/* Pad ring model. Inputs are de-inverted and then pass two flops, so the core
   sees a pad change two clocks later. The output and oe path is combinational. */

module pad_ring (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  output logic                                            rst_n_o,
  // Pad side
  input  chip_io_pkg::io_vec_t                            pad_in_i,
  output chip_io_pkg::io_vec_t                            pad_out_o,
  output chip_io_pkg::io_vec_t                            pad_oe_o,
  // Core side
  output chip_io_pkg::io_vec_t                            in_o,
  input  chip_io_pkg::io_vec_t                            out_i,
  input  chip_io_pkg::io_vec_t                            oe_i,
  input  chip_io_pkg::pad_attr_t [chip_io_pkg::NumIOs-1:0] attr_i
);

  import chip_io_pkg::*;

  logic [1:0] rst_sync_q;
  io_vec_t    inv, od;
  io_vec_t    in_meta_q, in_sync_q;

  // Assert asynchronously, release after two clocks
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rst_n_o = rst_sync_q[1];

  // Split the attribute fields
  always_comb begin
    for (int i = 0; i < NumIOs; i++) begin
      inv[i] = attr_i[i][0];
      od[i]  = attr_i[i][1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_o) begin
    if (!rst_n_o) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= pad_in_i ^ inv;
      in_sync_q <= in_meta_q;
    end
  end

  assign in_o = in_sync_q;

  assign pad_out_o = out_i ^ inv;
  // Open-drain pads only drive a 0
  assign pad_oe_o  = oe_i & ~(od & pad_out_o);

  assert property (@(posedge clk_i) disable iff (!rst_n_o)
    (pad_oe_o & od & pad_out_o) == '0)
    else $error("Open-drain pad driving a 1");

endmodule
